// File: Makefile
# Verilator build and run for the convolution stream testbench.
# Any variable below can be overridden on the command line, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_conv_stream
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run fails unless the log holds the pass line.
run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed" $(LOG) || { echo "simulation reported a failure"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_conv_stream.sv
// Assumes the 16x16 image of conv_pkg; $random uses seed 9 and the run stops after 4000 cycles.
`timescale 1ns/1ps

module tb_conv_stream
    import conv_pkg::*;
();

    typedef enum {READY_HIGH, READY_LOW, READY_RANDOM} ready_mode_t;

    // About twice the cycles that the whole sequence below needs.
    localparam int MAX_CYCLES = 4000;
    localparam int BP_ITEMS = 600;
    localparam int FULL_RATE_ITEMS = 48;

    logic clock_i;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    window_beat_t in_beat;
    logic coef_we;
    tap_t coef_tap;
    coef_t coef_data;
    logic out_valid;
    logic out_ready;
    result_beat_t out_beat;

    int seed = 9;
    ready_mode_t ready_mode = READY_HIGH;
    string test_name = "reset_state";
    int coef_model [KERNEL_TAPS];
    result_beat_t expected_q [$];
    int mismatch_errors = 0;
    int protocol_errors = 0;
    int checked_items = 0;
    int full_cycles = 0;
    int cycle_count = 0;

    conv_stream_top u_dut (.*);

    initial begin
        clock_i = 1'b0;
        forever #2 clock_i = ~clock_i;
    end

    // Sink model, out_ready only moves on a rising edge.
    initial begin
        out_ready = 1'b1;
        forever begin
            @(posedge clock_i);
            case (ready_mode)
                READY_HIGH: out_ready <= 1'b1;
                READY_LOW: out_ready <= 1'b0;
                default: out_ready <= 1'($random(seed));
            endcase
        end
    end

    initial begin
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clock_i);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
        print_summary();
        $display("Test failed");
        $finish;
    end

    // Zero padding, signed sum, floor division by 2**COEF_SHIFT, clamp to 0..255.
    function automatic pixel_t model_result(input window_beat_t beat);
        int sum;
        int row;
        int col;
        int tap;
        int scaled;
        pixel_t result;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                row = int'(beat.row) + dr;
                col = int'(beat.column) + dc;
                tap = (dr + 1) * 3 + (dc + 1);
                if (row >= 0 && row < IMAGE_HEIGHT && col >= 0 && col < IMAGE_WIDTH) begin
                    sum += int'(beat.window[tap]) * coef_model[tap];
                end
            end
        end
        scaled = sum / (1 << COEF_SHIFT);
        if (sum < 0 && scaled * (1 << COEF_SHIFT) != sum) begin
            scaled -= 1;
        end
        if (scaled < 0) begin
            result = '0;
        end else if (scaled > 255) begin
            result = 8'd255;
        end else begin
            result = pixel_t'(scaled);
        end
        return result;
    endfunction

    // Scoreboard. All reads see the values that were present before this edge.
    always @(posedge clock_i) begin
        result_beat_t expected;
        result_beat_t accepted;
        if (rst_n) begin
            // Three held items mean the skid buffer is in use.
            ready_check : assert (in_ready == (expected_q.size() < 3)) else begin
                protocol_errors++;
                $display("ERROR: %s: in_ready is %0b while %0d items are held",
                         test_name, in_ready, expected_q.size());
            end
            if (!in_ready) begin
                full_cycles++;
            end
            if (out_valid && out_ready) begin
                if (expected_q.size() == 0) begin
                    protocol_errors++;
                    $display("ERROR: %s: output transfer with no item outstanding", test_name);
                end else begin
                    expected = expected_q.pop_front();
                    checked_items++;
                    data_check : assert (out_beat == expected) else begin
                        mismatch_errors++;
                        $display("FAILED %s expected (%0d,%0d) %0d, actual (%0d,%0d) %0d",
                                 test_name, expected.row, expected.column, expected.data,
                                 out_beat.row, out_beat.column, out_beat.data);
                    end
                end
            end
            if (in_valid && in_ready) begin
                accepted.row = in_beat.row;
                accepted.column = in_beat.column;
                accepted.data = model_result(in_beat);
                expected_q.push_back(accepted);
            end
            // A write counts for windows accepted on later edges only.
            if (coef_we) begin
                coef_model[coef_tap] = int'(coef_data);
            end
        end
    end

    stall_hold : assert property (
        @(posedge clock_i) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else begin
        protocol_errors++;
        $display("ERROR: output dropped or changed during a stall");
    end

    task automatic print_summary();
        $display("Summary: %0d items checked, %0d data mismatches, %0d protocol errors",
                 checked_items, mismatch_errors, protocol_errors);
    endtask

    task automatic set_ready(input ready_mode_t mode);
        ready_mode <= mode;
        repeat (2) @(posedge clock_i);
    endtask

    task automatic send_window(input window_beat_t beat);
        in_valid <= 1'b1;
        in_beat <= beat;
        @(posedge clock_i);
        while (!in_ready) begin
            @(posedge clock_i);
        end
        in_valid <= 1'b0;
    endtask

    task automatic load_kernel(input coef_bank_t bank);
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            coef_we <= 1'b1;
            coef_tap <= tap_t'(t);
            coef_data <= bank[t];
            @(posedge clock_i);
        end
        coef_we <= 1'b0;
    endtask

    task automatic drain_outputs();
        while (expected_q.size() != 0) begin
            @(posedge clock_i);
        end
    endtask

    function automatic window_beat_t make_beat(input int row, input int col, input window_t w);
        window_beat_t beat;
        beat.row = row_t'(row);
        beat.column = col_t'(col);
        beat.window = w;
        return beat;
    endfunction

    function automatic window_t random_window();
        window_t w;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            w[t] = pixel_t'($random(seed));
        end
        return w;
    endfunction

    function automatic window_t uniform_window(input int value);
        window_t w;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            w[t] = pixel_t'(value);
        end
        return w;
    endfunction

    function automatic coef_bank_t uniform_kernel(input int value);
        coef_bank_t bank;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            bank[t] = coef_t'(value);
        end
        return bank;
    endfunction

    // Random interior windows, then a full-scale window and a dark centre in a bright ring.
    task automatic run_arith(input coef_bank_t bank);
        window_t dark_centre;
        dark_centre = uniform_window(255);
        dark_centre[4] = '0;
        load_kernel(bank);
        repeat (16) begin
            send_window(make_beat(1 + {$random(seed)} % 14, 1 + {$random(seed)} % 14,
                                  random_window()));
        end
        send_window(make_beat(5, 9, uniform_window(255)));
        send_window(make_beat(9, 5, dark_centre));
        drain_outputs();
    endtask

    initial begin
        coef_bank_t bank;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_beat = '0;
        coef_we = 1'b0;
        coef_tap = '0;
        coef_data = '0;
        repeat (2) @(posedge clock_i);
        rst_n <= 1'b1;

        repeat (3) begin
            @(posedge clock_i);
            reset_check : assert (!out_valid && in_ready) else begin
                protocol_errors++;
                $display("ERROR: out_valid high or in_ready low just after reset");
            end
        end
        // The bank is still all zero, so the model expects 0 here.
        repeat (4) begin
            send_window(make_beat({$random(seed)} % 16, {$random(seed)} % 16, random_window()));
        end
        drain_outputs();

        test_name = "arith_identity";
        bank = uniform_kernel(0);
        bank[4] = 16;
        run_arith(bank);
        test_name = "arith_box";
        run_arith(uniform_kernel(2));
        test_name = "arith_edge";
        bank = uniform_kernel(-2);
        bank[4] = 24;
        run_arith(bank);

        // Distinct weights, so every result names the taps that stayed inside.
        test_name = "border_padding";
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            bank[t] = coef_t'(t + 1);
        end
        load_kernel(bank);
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                send_window(make_beat(r * 15 / 2, c * 15 / 2, uniform_window(16)));
                send_window(make_beat(r * 15 / 2, c * 15 / 2, random_window()));
            end
        end
        drain_outputs();

        test_name = "back_pressure";
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            bank[t] = coef_t'($random(seed) % 8);
        end
        load_kernel(bank);
        set_ready(READY_RANDOM);
        for (int i = 0; i < BP_ITEMS; i++) begin
            if ($random(seed) % 4 == 0) begin
                @(posedge clock_i);
            end
            send_window(make_beat({$random(seed)} % 16, {$random(seed)} % 16, random_window()));
        end
        drain_outputs();
        skid_used : assert (full_cycles > 0) else begin
            protocol_errors++;
            $display("ERROR: in_ready never dropped, the skid buffer was not exercised");
        end

        // The first burst stays stalled inside the DUT while the bank is rewritten.
        test_name = "coef_reload";
        set_ready(READY_HIGH);
        load_kernel(uniform_kernel(2));
        set_ready(READY_LOW);
        repeat (3) begin
            send_window(make_beat(4, 4, random_window()));
        end
        bank = uniform_kernel(-2);
        bank[4] = 24;
        load_kernel(bank);
        set_ready(READY_HIGH);
        repeat (8) begin
            send_window(make_beat(6, 6, random_window()));
        end
        drain_outputs();

        test_name = "full_rate";
        for (int i = 0; i < FULL_RATE_ITEMS; i++) begin
            in_valid <= 1'b1;
            in_beat <= make_beat(i % 16, (i * 5) % 16, random_window());
            @(posedge clock_i);
            // Item i - 2 leaves on the edge where item i enters.
            rate_check : assert (in_ready && (i < 2 || out_valid)) else begin
                protocol_errors++;
                $display("ERROR: full_rate stalled on beat %0d", i);
            end
        end
        in_valid <= 1'b0;
        drain_outputs();
        repeat (4) @(posedge clock_i);

        print_summary();
        if (mismatch_errors == 0 && protocol_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : tb_conv_stream

// File: verilog.f
verilog/conv_pkg.sv
verilog/conv_window_decoder.sv
verilog/conv_kernel.sv
verilog/conv_multiplier.sv
verilog/conv_stream_top.sv
sim/tb_conv_stream.sv

// File: verilog/conv_kernel.sv
// Coefficient writes must not coincide with an accepted window; the output is clamped to 0..255.
`timescale 1ns/1ps

module conv_kernel
    import conv_pkg::*;
(
    input  logic    clock_i,
    input  logic    rst_n,
    input  logic    coef_we,
    input  tap_t    coef_tap,
    input  coef_t   coef_data,
    input  logic    enable,
    input  window_t window,
    output pixel_t  result
);

    coef_bank_t coef_bank;
    acc_t sum;
    acc_t shifted;
    pixel_t clamped;

    // Coefficient bank, all zero after reset.
    always_ff @(posedge clock_i) begin
        if (!rst_n) begin
            coef_bank <= '0;
        end else if (coef_we && coef_tap < KERNEL_TAPS) begin
            coef_bank[coef_tap] <= coef_data;
        end
    end

    // Nine signed products, pixels are zero extended first.
    always_comb begin
        sum = '0;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            sum = sum + acc_t'({1'b0, window[i]}) * acc_t'($signed(coef_bank[i]));
        end
    end

    // Arithmetic shift floors toward minus infinity.
    assign shifted = sum >>> COEF_SHIFT;

    always_comb begin
        if (shifted < 0) begin
            clamped = '0;
        end else if (shifted > acc_t'(2 ** ITEM_BITS - 1)) begin
            clamped = '1;
        end else begin
            clamped = pixel_t'(shifted);
        end
    end

    // Result register, loaded only when a window is accepted.
    always_ff @(posedge clock_i) begin
        if (enable) begin
            result <= clamped;
        end
    end

    // Writes past tap 8 are dropped, which would leave a stale coefficient behind.
    a_coef_tap_range : assert property (
        @(posedge clock_i) disable iff (!rst_n)
        coef_we |-> coef_tap < KERNEL_TAPS
    ) else $error("coefficient write to tap %0d", coef_tap);

    // A write in the same cycle as an accepted window would split the bank across it
    a_coef_write_idle : assert property (
        @(posedge clock_i) disable iff (!rst_n)
        coef_we |-> !enable
    ) else $error("coefficient write while a window is accepted");

endmodule : conv_kernel

// File: verilog/conv_multiplier.sv
// Holds up to three results (output, kernel register, skid buffer); in_ready is low only when full.
`timescale 1ns/1ps

module conv_multiplier
    import conv_pkg::*;
(
    input  logic         clock_i,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  window_beat_t in_beat,
    output logic         kernel_enable,
    input  pixel_t       kernel_result,
    output logic         out_valid,
    input  logic         out_ready,
    output result_beat_t out_beat
);

    logic has_new_input;
    logic has_pending_output;
    logic move_skid;
    logic move_kernel;
    logic fill_skid;

    // Kernel register is valid until its value leaves for the output or the skid buffer.
    logic kernel_valid;
    row_t kernel_row;
    col_t kernel_col;
    result_beat_t kernel_beat;

    // Skid buffer, occupied exactly when in_ready is low.
    result_beat_t skid_beat;

    assign has_new_input = in_valid && in_ready;
    assign has_pending_output = out_valid && !out_ready;
    assign kernel_enable = has_new_input;

    // The skid buffer always drains ahead of the kernel register.
    assign move_skid = !has_pending_output && !in_ready;
    assign move_kernel = !has_pending_output && in_ready;
    assign fill_skid = has_new_input && has_pending_output;

    assign kernel_beat = '{row: kernel_row, column: kernel_col, data: kernel_result};

    always_ff @(posedge clock_i) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            in_ready <= 1'b1;
            kernel_valid <= 1'b0;
        end else begin
            if (move_skid) begin
                out_valid <= 1'b1;
                in_ready <= 1'b1;
            end else if (move_kernel) begin
                out_valid <= kernel_valid;
            end
            // An empty kernel register leaves nothing for the skid buffer to hold.
            if (fill_skid) begin
                in_ready <= !kernel_valid;
            end
            if (has_new_input) begin
                kernel_valid <= 1'b1;
            end else if (move_kernel) begin
                kernel_valid <= 1'b0;
            end
        end
    end

    // Payload registers follow the same moves as the flags above.
    always_ff @(posedge clock_i) begin
        if (move_skid) begin
            out_beat <= skid_beat;
        end else if (move_kernel) begin
            out_beat <= kernel_beat;
        end
        if (fill_skid) begin
            skid_beat <= kernel_beat;
        end
        if (has_new_input) begin
            kernel_row <= in_beat.row;
            kernel_col <= in_beat.column;
        end
    end

    a_out_stable : assert property (
        @(posedge clock_i) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("output changed during a stall");

    // A free output always drains the skid buffer on the next edge.
    a_ready_recovers : assert property (
        @(posedge clock_i) disable iff (!rst_n)
        (!in_ready && out_ready) |=> in_ready
    ) else $error("in_ready stayed low after an output transfer");

endmodule : conv_multiplier

// File: verilog/conv_pkg.sv
// Build is fixed at a 16x16 image, 8-bit pixels and a 3x3 kernel; there is no runtime sizing.
package conv_pkg;

    // Image geometry.
    localparam int IMAGE_HEIGHT = 16;
    localparam int IMAGE_WIDTH = 16;
    localparam int ROW_BITS = $clog2(IMAGE_HEIGHT);
    localparam int COL_BITS = $clog2(IMAGE_WIDTH);

    // Pixel and kernel arithmetic.
    localparam int ITEM_BITS = 8;
    localparam int COEF_BITS = 8;
    localparam int KERNEL_SIDE = 3;
    localparam int KERNEL_TAPS = KERNEL_SIDE * KERNEL_SIDE;
    localparam int TAP_BITS = 4;
    localparam int ACC_BITS = 20;
    localparam int COEF_SHIFT = 4;

    typedef logic [ITEM_BITS-1:0] pixel_t;
    typedef logic signed [COEF_BITS-1:0] coef_t;
    typedef logic signed [ACC_BITS-1:0] acc_t;
    typedef logic [ROW_BITS-1:0] row_t;
    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [TAP_BITS-1:0] tap_t;

    // Row-major window, index 0 is the top-left pixel.
    typedef pixel_t [KERNEL_TAPS-1:0] window_t;

    typedef coef_t [KERNEL_TAPS-1:0] coef_bank_t;

    // One input item, tagged with the position of its centre pixel.
    typedef struct packed {
        row_t row;
        col_t column;
        window_t window;
    } window_beat_t;

    // One output item.
    typedef struct packed {
        row_t row;
        col_t column;
        pixel_t data;
    } result_beat_t;

endpackage : conv_pkg

// File: verilog/conv_stream_top.sv
// Coefficients are loaded through a plain strobe and must only change between accepted windows.
`timescale 1ns/1ps

module conv_stream_top
    import conv_pkg::*;
(
    input  logic         clock_i,
    input  logic         rst_n,
    input  logic         in_valid,
    output logic         in_ready,
    input  window_beat_t in_beat,
    input  logic         coef_we,
    input  tap_t         coef_tap,
    input  coef_t        coef_data,
    output logic         out_valid,
    input  logic         out_ready,
    output result_beat_t out_beat
);

    window_beat_t padded_beat;
    logic kernel_enable;
    pixel_t kernel_result;

    conv_window_decoder u_decoder (
        .clock_i     (clock_i),
        .take        (kernel_enable),
        .in_beat     (in_beat),
        .padded_beat (padded_beat)
    );

    conv_kernel u_kernel (
        .clock_i   (clock_i),
        .rst_n     (rst_n),
        .coef_we   (coef_we),
        .coef_tap  (coef_tap),
        .coef_data (coef_data),
        .enable    (kernel_enable),
        .window    (padded_beat.window),
        .result    (kernel_result)
    );

    // The result stage only needs the coordinates of the raw beat.
    conv_multiplier u_result (
        .clock_i       (clock_i),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_beat       (in_beat),
        .kernel_enable (kernel_enable),
        .kernel_result (kernel_result),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_beat      (out_beat)
    );

endmodule : conv_stream_top

// File: verilog/conv_window_decoder.sv
// Purely combinational; the centre coordinate must lie inside the image when take is high.
`timescale 1ns/1ps

module conv_window_decoder
    import conv_pkg::*;
(
    input  logic         clock_i,
    input  logic         take,
    input  window_beat_t in_beat,
    output window_beat_t padded_beat
);

    // Tap t sits at row offset t / 3 - 1 and column offset t % 3 - 1.
    always_comb begin
        int nbr_row;
        int nbr_col;
        nbr_row = 0;
        nbr_col = 0;
        padded_beat = in_beat;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            nbr_row = int'(in_beat.row) + t / KERNEL_SIDE - 1;
            nbr_col = int'(in_beat.column) + t % KERNEL_SIDE - 1;
            // Outside the image counts as zero.
            if (nbr_row < 0 || nbr_row >= IMAGE_HEIGHT ||
                    nbr_col < 0 || nbr_col >= IMAGE_WIDTH) begin
                padded_beat.window[t] = '0;
            end
        end
    end

    // The padding above only covers one pixel around the image, so a centre outside
    // the image would produce a window with no valid relation to the frame.
    a_centre_in_image : assert property (
        @(posedge clock_i)
        take |-> (int'(in_beat.row) < IMAGE_HEIGHT && int'(in_beat.column) < IMAGE_WIDTH)
    ) else $error("window centre outside image: row %0d column %0d",
                  in_beat.row, in_beat.column);

endmodule : conv_window_decoder
